// ==== rtl/mult_pkg.sv ====
package mult_pkg;

    // Operand and product widths
    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // One step per multiplier bit, the last one is the sign step
    localparam int NUM_STEPS = OPERAND_W;
    localparam int COUNT_W   = $clog2(NUM_STEPS);

    // Signed operand, two's complement
    typedef logic [OPERAND_W-1:0] operand_t;

    // Signed product, two's complement
    typedef logic [PRODUCT_W-1:0] product_t;

    // Index of the multiplier bit under examination
    typedef logic [COUNT_W-1:0] step_count_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0, // Waiting for an operand pair
        CALC   = 2'd1, // One bit step per cycle
        RESULT = 2'd2  // Product held for the consumer
    } mult_state_t;

endpackage

// ==== rtl/mult_controller.sv ====
`timescale 1ns/1ps

module mult_controller
    import mult_pkg::*;
(
    input  logic clk,
    input  logic n_rst,

    // Source stream
    input  logic src_valid_i,
    output logic src_ready_o,

    // Destination stream
    input  logic dst_ready_i,
    output logic dst_valid_o,

    // Datapath flags
    input  logic mult_bit_i,
    input  logic count_last_i,

    // Datapath enables
    output logic load_o,
    output logic step_en_o,
    output logic add_o,
    output logic sub_o,
    output logic result_en_o
);

    mult_state_t state_q;
    mult_state_t state_d;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (src_valid_i) begin
                    state_d = CALC; // Operands taken on this edge
                end
            end

            CALC: begin
                if (count_last_i) begin
                    state_d = RESULT; // Sign step done, product loaded
                end
            end

            RESULT: begin
                if (dst_ready_i) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Outputs, all zero unless the state asks for them
    always_comb begin
        src_ready_o = 1'b0;
        dst_valid_o = 1'b0;
        load_o      = 1'b0;
        step_en_o   = 1'b0;
        add_o       = 1'b0;
        sub_o       = 1'b0;
        result_en_o = 1'b0;

        case (state_q)
            IDLE: begin
                src_ready_o = 1'b1;
                load_o      = src_valid_i; // Load on the acceptance edge
            end

            CALC: begin
                step_en_o = 1'b1;
                if (count_last_i) begin
                    // Bit 15 carries weight -2^15
                    sub_o       = mult_bit_i;
                    result_en_o = 1'b1;
                end else begin
                    add_o = mult_bit_i;
                end
            end

            RESULT: begin
                dst_valid_o = 1'b1; // Held until dst_ready_i
            end

            default: begin
                src_ready_o = 1'b0;
                dst_valid_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/mult_datapath.sv ====
`timescale 1ns/1ps

module mult_datapath
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,

    // Operands from the source stream
    input  operand_t multiplicand_i,
    input  operand_t multiplier_i,

    // Enables from the controller
    input  logic     load_i,
    input  logic     step_en_i,
    input  logic     add_i,
    input  logic     sub_i,
    input  logic     result_en_i,

    // Flags to the controller
    output logic     mult_bit_o,
    output logic     count_last_o,

    // Result
    output product_t product_o
);

    localparam step_count_t LAST_STEP = step_count_t'(NUM_STEPS - 1);

    product_t    mcand_q;   // Multiplicand, sign-extended
    operand_t    mplier_q;  // Multiplier, shifted right each step
    step_count_t count_q;
    product_t    acc_q;
    product_t    product_q;

    product_t    aligned;
    product_t    acc_d;

    // Multiplicand weighted by the current bit position
    assign aligned = mcand_q << count_q;

    always_comb begin
        acc_d = acc_q;
        if (add_i) begin
            acc_d = acc_q + aligned;
        end else if (sub_i) begin
            acc_d = acc_q - aligned; // Sign step only
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            mcand_q <= '0;
        end else if (load_i) begin
            mcand_q <= {{(PRODUCT_W - OPERAND_W){multiplicand_i[OPERAND_W-1]}}, multiplicand_i};
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            mplier_q <= '0;
        end else if (load_i) begin
            mplier_q <= multiplier_i;
        end else if (step_en_i) begin
            mplier_q <= {1'b0, mplier_q[OPERAND_W-1:1]}; // Next bit into bit 0
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= '0;
        end else if (step_en_i) begin
            count_q <= step_count_t'(count_q + 1'b1); // Wraps after the sign step
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            acc_q <= '0;
        end else if (load_i) begin
            acc_q <= '0;
        end else if (step_en_i) begin
            acc_q <= acc_d;
        end
    end

    // Takes the final sum on the same edge as the last step
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            product_q <= '0;
        end else if (result_en_i) begin
            product_q <= acc_d;
        end
    end

    assign mult_bit_o   = mplier_q[0];
    assign count_last_o = (count_q == LAST_STEP);
    assign product_o    = product_q;

endmodule

// ==== rtl/seq_multiplier.sv ====
`timescale 1ns/1ps

module seq_multiplier
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,

    // Source side
    input  logic     src_valid_i,
    output logic     src_ready_o,
    input  operand_t multiplicand_i,
    input  operand_t multiplier_i,

    // Destination side
    output logic     dst_valid_o,
    input  logic     dst_ready_i,
    output product_t product_o
);

    logic load;
    logic step_en;
    logic add;
    logic sub;
    logic result_en;
    logic mult_bit;
    logic count_last;

    mult_controller mult_controller_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .src_valid_i  (src_valid_i),
        .src_ready_o  (src_ready_o),
        .dst_ready_i  (dst_ready_i),
        .dst_valid_o  (dst_valid_o),
        .mult_bit_i   (mult_bit),
        .count_last_i (count_last),
        .load_o       (load),
        .step_en_o    (step_en),
        .add_o        (add),
        .sub_o        (sub),
        .result_en_o  (result_en)
    );

    mult_datapath mult_datapath_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .load_i         (load),
        .step_en_i      (step_en),
        .add_i          (add),
        .sub_i          (sub),
        .result_en_i    (result_en),
        .mult_bit_o     (mult_bit),
        .count_last_o   (count_last),
        .product_o      (product_o)
    );

endmodule

// ==== test/tb_mult_model.svh ====
`ifndef TB_MULT_MODEL_SVH
`define TB_MULT_MODEL_SVH

// Plain integer product of the two signed operands
function automatic product_t expected_product(input operand_t a, input operand_t b);
    int sa;
    int sb;
    sa = int'($signed(a));
    sb = int'($signed(b));
    return product_t'(sa * sb);
endfunction

// Called on a falling edge, returns on the falling edge after acceptance
task automatic send_pair(input operand_t a, input operand_t b);
    src_valid_i    = 1'b1;
    multiplicand_i = a;
    multiplier_i   = b;
    while (!src_ready_o) begin
        @(negedge clk);
    end
    @(negedge clk); // Acceptance edge has passed
    src_valid_i = 1'b0;
endtask

// max_stall of 0 keeps dst_ready_i high the whole time
task automatic collect_products(input int count, input int max_stall);
    int stall;
    for (int i = 0; i < count; i++) begin
        stall = (max_stall > 0) ? $urandom_range(max_stall, 0) : 0;
        dst_ready_i = (max_stall == 0);
        while (!dst_valid_o) begin
            @(negedge clk);
        end
        repeat (stall) @(negedge clk);
        dst_ready_i = 1'b1;
        got_q.push_back(product_o);
        @(negedge clk); // Transfer edge has passed
    end
    dst_ready_i = (max_stall == 0);
endtask

`endif

// ==== test/tb_seq_multiplier.sv ====
`timescale 1ns/1ps

module tb_seq_multiplier
    import mult_pkg::*;
();

    localparam int CLK_HALF       = 4;
    localparam int RESET_CYCLES   = 4;
    localparam int SEED           = 28126;
    localparam int MAX_OPS        = 200;
    localparam int CYCLES_PER_OP  = 40;
    localparam int TIMEOUT_CYCLES = MAX_OPS * CYCLES_PER_OP + 200;
    localparam int NUM_CORNERS    = 10;
    localparam int NUM_RANDOM     = 150;
    localparam int NUM_STALLED    = 20;
    localparam int NUM_FLOOD      = 15;
    localparam int MAX_STALL      = 10;

    localparam operand_t CORNER_A [NUM_CORNERS] = '{
        16'h0000, 16'h7FFF, 16'h0001, 16'hFFFF, 16'h8000,
        16'h8000, 16'h7FFF, 16'hAAAA, 16'h5555, 16'hAAAA
    };
    localparam operand_t CORNER_B [NUM_CORNERS] = '{
        16'h1234, 16'h0000, 16'hFFFF, 16'h0001, 16'h8000,
        16'h7FFF, 16'h7FFF, 16'h5555, 16'h5555, 16'hAAAA
    };

    logic     clk;
    logic     n_rst;
    logic     src_valid_i;
    logic     src_ready_o;
    operand_t multiplicand_i;
    operand_t multiplier_i;
    logic     dst_valid_o;
    logic     dst_ready_i;
    product_t product_o;

    product_t exp_q[$];          // Expected products in acceptance order
    product_t got_q[$];
    product_t exp_head  = '0;
    product_t prod_q    = '0;    // Product seen on the previous edge
    logic     busy      = 1'b0;  // Between acceptance and transfer
    logic     hold_q    = 1'b0;  // Previous edge was a stalled result
    int       since_acc = 0;
    int       n_accept  = 0;
    int       n_xfer    = 0;     // Destination transfers seen on the bus
    int       errors    = 0;
    string    test_name = "reset";

    `include "tb_mult_model.svh"

    seq_multiplier seq_multiplier_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .src_valid_i    (src_valid_i),
        .src_ready_o    (src_ready_o),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .dst_valid_o    (dst_valid_o),
        .dst_ready_i    (dst_ready_i),
        .product_o      (product_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Tracks acceptances and transfers as seen on each rising edge
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy      <= 1'b0;
            hold_q    <= 1'b0;
            prod_q    <= '0;
            since_acc <= 0;
            exp_head  <= '0;
            exp_q.delete();
        end else begin
            hold_q <= dst_valid_o && !dst_ready_i;
            prod_q <= product_o;
            if (src_valid_i && src_ready_o) begin
                exp_q.push_back(expected_product(multiplicand_i, multiplier_i));
                n_accept++;
                busy      <= 1'b1;
                since_acc <= 1;
            end else if (busy) begin
                since_acc <= since_acc + 1;
            end
            if (dst_valid_o && dst_ready_i) begin
                n_xfer++;
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                busy <= 1'b0;
            end
            exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
        end
    end

    task automatic log_mismatch(input string check, input product_t expected,
                                input product_t actual);
        errors++;
        $display("CHECK FAILED %s/%s: expected 0x%08h, actual 0x%08h",
                 test_name, check, expected, actual);
    endtask

    reset_state: assert property (@(posedge clk) !n_rst |-> (src_ready_o && !dst_valid_o))
        else log_mismatch("reset state", product_t'(2'b10),
                          product_t'({$sampled(src_ready_o), $sampled(dst_valid_o)}));

    idle_state: assert property (@(posedge clk) !busy |-> (src_ready_o && !dst_valid_o))
        else log_mismatch("idle state", product_t'(2'b10),
                          product_t'({$sampled(src_ready_o), $sampled(dst_valid_o)}));

    no_accept_busy: assert property (@(posedge clk) disable iff (!n_rst)
        busy |-> !src_ready_o)
        else log_mismatch("src_ready while busy", '0, product_t'($sampled(src_ready_o)));

    // Valid is first seen on the edge after the sixteenth step
    fixed_latency: assert property (@(posedge clk) disable iff (!n_rst)
        busy |-> (dst_valid_o == (since_acc > NUM_STEPS)))
        else log_mismatch("latency", product_t'($sampled(since_acc) > NUM_STEPS),
                          product_t'($sampled(dst_valid_o)));

    product_value: assert property (@(posedge clk) disable iff (!n_rst)
        (dst_valid_o && dst_ready_i) |-> (product_o == exp_head))
        else log_mismatch("product", $sampled(exp_head), $sampled(product_o));

    hold_valid: assert property (@(posedge clk) disable iff (!n_rst)
        hold_q |-> dst_valid_o)
        else log_mismatch("valid under stall", product_t'(1'b1),
                          product_t'($sampled(dst_valid_o)));

    hold_product: assert property (@(posedge clk) disable iff (!n_rst)
        hold_q |-> (product_o == prod_q))
        else log_mismatch("product under stall", $sampled(prod_q), $sampled(product_o));

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_pair(operand_t'($urandom), operand_t'($urandom));
        end
    endtask

    // Valid stays high with new data every cycle until count pairs are taken
    task automatic flood_source(input int count);
        int accepted;
        accepted = 0;
        while (accepted < count) begin
            src_valid_i    = 1'b1;
            multiplicand_i = operand_t'($urandom);
            multiplier_i   = operand_t'($urandom);
            if (src_ready_o) begin
                accepted++; // Taken on the coming edge
            end
            @(negedge clk);
        end
        src_valid_i = 1'b0;
    endtask

    initial begin
        int count_errors;
        count_errors   = 0;
        void'($urandom(SEED));
        n_rst          = 1'b1;
        src_valid_i    = 1'b0;
        multiplicand_i = '0;
        multiplier_i   = '0;
        dst_ready_i    = 1'b0;
        #1 n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);

        test_name = "corners";
        fork
            begin
                for (int i = 0; i < NUM_CORNERS; i++) begin
                    send_pair(CORNER_A[i], CORNER_B[i]);
                end
            end
            collect_products(NUM_CORNERS, 0);
        join

        test_name = "random";
        fork
            send_random(NUM_RANDOM);
            collect_products(NUM_RANDOM, 0);
        join

        test_name = "backpressure";
        fork
            send_random(NUM_STALLED);
            collect_products(NUM_STALLED, MAX_STALL);
        join

        test_name = "busy source";
        fork
            flood_source(NUM_FLOOD);
            collect_products(NUM_FLOOD, 3);
        join

        dst_ready_i = 1'b1; // Any extra product would transfer here
        repeat (4) @(negedge clk);
        product_count: assert (n_accept == n_xfer && got_q.size() == n_xfer) else begin
            count_errors = 1;
            $display("Transfers (%0d) and products collected (%0d) differ from pairs (%0d)",
                     n_xfer, got_q.size(), n_accept);
        end
        $display("Errors: %0d check, %0d count; products collected: %0d",
                 errors, count_errors, got_q.size());
        if (errors == 0 && count_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("The run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Errors: %0d check; products collected: %0d", errors, got_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+test
rtl/mult_pkg.sv
rtl/mult_controller.sv
rtl/mult_datapath.sv
rtl/seq_multiplier.sv
test/tb_seq_multiplier.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_seq_multiplier
OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f sources.f --top-module "$TOP" -Mdir "$OBJ_DIR"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
    echo "Simulation reported failure, see $LOG_FILE"
    exit 1
fi

echo "Simulation passed"
exit 0
